//--- verilog.f
hw/msg_pkg.sv
hw/core_msg_fifo.sv
hw/core_msg_arbiter.sv
hw/slot_tracker.sv
hw/riscv_msg_ctrl.sv
tests/tb_riscv_msg_ctrl.sv

//--- Makefile
# Verilator build and run of the message controller testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_msg_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a $fatal in the testbench gives a nonzero exit status, which fails make
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_riscv_msg_ctrl.sv
`timescale 1ns/100ps

module tb_riscv_msg_ctrl;

  typedef struct packed {
    logic              found;
    msg_pkg::rx_desc_t desc;
  } desc_pred_t;

  typedef struct packed {
    logic [msg_pkg::CORE_NO_WIDTH-1:0] core_no;
    logic [msg_pkg::MSG_WIDTH-1:0]     word;
  } model_msg_t;

  logic                                         logic_clk;
  logic                                         rst_n;
  logic [msg_pkg::CORE_COUNT-1:0]               core_msg_valid;
  msg_pkg::core_msg_u [msg_pkg::CORE_COUNT-1:0] core_msg_data;
  logic                                         pkt_arrival;
  logic                                         rx_desc_ready;
  msg_pkg::rx_desc_t                            rx_desc;
  logic                                         rx_desc_valid;
  logic [msg_pkg::CORE_COUNT-1:0]               msg_overflow;

  // reference model state
  logic [msg_pkg::CORE_COUNT-1:0][msg_pkg::SLOT_COUNT-1:0] m_busy;
  logic [msg_pkg::CORE_COUNT-1:0]                          m_en;
  logic [msg_pkg::CORE_NO_WIDTH-1:0]                       m_last;
  int                                                      m_pending;
  desc_pred_t                                              pred;
  model_msg_t                                              model_msg;
  logic                                                    model_msg_valid;

  logic [msg_pkg::CORE_COUNT-1:0] ovf_allowed;
  logic                           stall_en;
  logic                           msgs_drained;
  logic                           desc_idle;
  string                          test_name;
  int                             seed;

  riscv_msg_ctrl u_riscv_msg_ctrl (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .core_msg_valid (core_msg_valid),
    .core_msg_data  (core_msg_data),
    .pkt_arrival    (pkt_arrival),
    .rx_desc_ready  (rx_desc_ready),
    .rx_desc        (rx_desc),
    .rx_desc_valid  (rx_desc_valid),
    .msg_overflow   (msg_overflow)
  );

  always #20 logic_clk = ~logic_clk;

  // lowest free slot of the next enabled core after the last one served
  function automatic desc_pred_t predict_desc(
    input logic [msg_pkg::CORE_COUNT-1:0][msg_pkg::SLOT_COUNT-1:0] busy,
    input logic [msg_pkg::CORE_COUNT-1:0]                          en,
    input logic [msg_pkg::CORE_NO_WIDTH-1:0]                       last
  );
    desc_pred_t p;
    int         c;
    p = '0;
    for (int k = 1; k <= msg_pkg::CORE_COUNT; k++) begin
      c = (int'(last) + k) % msg_pkg::CORE_COUNT;
      if (!p.found && en[c] && (busy[c] != '1)) begin
        p.found        = 1'b1;
        p.desc.core_no = c[msg_pkg::CORE_NO_WIDTH-1:0];
        for (int s = msg_pkg::SLOT_COUNT - 1; s >= 0; s--) begin
          if (!busy[c][s]) begin
            p.desc.slot_no = s[msg_pkg::SLOT_NO_WIDTH-1:0];
          end
        end
      end
    end
    return p;
  endfunction

  function automatic logic [msg_pkg::MSG_WIDTH-1:0] slot_free_word(input logic [2:0] slot);
    return {msg_pkg::MSG_SLOT_FREE, 59'd0, slot};
  endfunction

  function automatic logic [msg_pkg::MSG_WIDTH-1:0] core_status_word(input logic accept);
    return {msg_pkg::MSG_CORE_STATUS, 61'd0, accept};
  endfunction

  assign pred         = predict_desc(m_busy, m_en, m_last);
  assign msgs_drained = (u_riscv_msg_ctrl.u_core_msg_arbiter.fifo_empty == '1)
                     && !u_riscv_msg_ctrl.msg_valid;
  assign desc_idle    = (m_pending == 0) && !rx_desc_valid;

  always @(posedge logic_clk) begin
    if (!rst_n) begin
      m_busy    <= '0;
      m_en      <= '1;
      m_last    <= '1;
      m_pending <= 0;
    end else begin
      if (rx_desc_valid && rx_desc_ready) begin
        m_busy[pred.desc.core_no][pred.desc.slot_no] <= 1'b1;
        m_last                                       <= pred.desc.core_no;
      end
      if (pkt_arrival && !(rx_desc_valid && rx_desc_ready)
          && (m_pending < msg_pkg::PENDING_MAX)) begin
        m_pending <= m_pending + 1;
      end else if (!pkt_arrival && rx_desc_valid && rx_desc_ready) begin
        m_pending <= m_pending - 1;
      end
      // unknown type codes change nothing
      if (model_msg_valid) begin
        if (model_msg.word[63:62] == msg_pkg::MSG_SLOT_FREE) begin
          m_busy[model_msg.core_no][model_msg.word[2:0]] <= 1'b0;
        end else if (model_msg.word[63:62] == msg_pkg::MSG_CORE_STATUS) begin
          m_en[model_msg.core_no] <= model_msg.word[0];
        end
      end
    end
  end

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  a_desc_matches_model: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (rx_desc_valid && rx_desc_ready) |-> (rx_desc == pred.desc)
  ) else fail_now($sformatf("[ERROR] %s: expected core %0d slot %0d, actual core %0d slot %0d",
    test_name, $sampled(pred.desc.core_no), $sampled(pred.desc.slot_no),
    $sampled(rx_desc.core_no), $sampled(rx_desc.slot_no)));

  a_desc_expected: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    rx_desc_valid |-> pred.found
  ) else fail_now($sformatf("%s: descriptor offered while no enabled core has a free slot",
    test_name));

  a_desc_held: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (rx_desc_valid && !rx_desc_ready) |=> (rx_desc_valid && $stable(rx_desc))
  ) else fail_now($sformatf("%s: descriptor dropped or changed before its transfer", test_name));

  a_arrival_latency: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (pkt_arrival && !rx_desc_valid && pred.found) |=> rx_desc_valid
  ) else fail_now($sformatf("%s: no descriptor one cycle after an arrival with a free slot",
    test_name));

  a_no_early_overflow: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (msg_overflow & ~ovf_allowed) == '0
  ) else fail_now($sformatf("[ERROR] %s: expected msg_overflow %h, actual %h",
    test_name, $sampled(msg_overflow & ovf_allowed), $sampled(msg_overflow)));

  a_overflow_sticky: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (msg_overflow & $past(msg_overflow)) == $past(msg_overflow)
  ) else fail_now($sformatf("%s: an overflow flag cleared without reset", test_name));

  // ready is random only while stalling
  task automatic next_cycle();
    @(posedge logic_clk);
    rx_desc_ready <= stall_en ? (($random(seed) & 1) == 1) : 1'b1;
  endtask

  task automatic apply_reset();
    next_cycle();
    rst_n <= 1'b0;
    repeat (5) next_cycle();
    rst_n <= 1'b1;
  endtask

  task automatic send_arrivals(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
      pkt_arrival <= 1'b1;
    end
    next_cycle();
    pkt_arrival <= 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge logic_clk);
    while (!desc_idle && cycles < 200) begin
      next_cycle();
      @(negedge logic_clk);
      cycles++;
    end
    if (!desc_idle) begin
      fail_now($sformatf("%s: pending arrivals not served within 200 cycles", test_name));
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    @(negedge logic_clk);
    while (!msgs_drained && cycles < 200) begin
      next_cycle();
      @(negedge logic_clk);
      cycles++;
    end
    if (!msgs_drained) begin
      fail_now($sformatf("%s: core messages did not drain within 200 cycles", test_name));
    end
  endtask

  // the model catches up once the message has landed
  task automatic send_msg(input int core, input logic [msg_pkg::MSG_WIDTH-1:0] word);
    next_cycle();
    core_msg_valid[core] <= 1'b1;
    core_msg_data[core]  <= msg_pkg::core_msg_u'(word);
    next_cycle();
    core_msg_valid <= '0;
    wait_drained();
    next_cycle();
    model_msg_valid <= 1'b1;
    model_msg       <= '{core_no: core[msg_pkg::CORE_NO_WIDTH-1:0], word: word};
    next_cycle();
    model_msg_valid <= 1'b0;
  endtask

  initial begin
    int core;
    logic_clk       = 1'b0;
    rst_n           = 1'b0;
    core_msg_valid  = '0;
    core_msg_data   = '0;
    pkt_arrival     = 1'b0;
    rx_desc_ready   = 1'b1;
    model_msg_valid = 1'b0;
    model_msg       = '0;
    ovf_allowed     = '0;
    stall_en        = 1'b0;
    seed            = 57;
    test_name       = "allocation_order";
    apply_reset();

    send_arrivals(128);
    wait_idle();
    // one more arrival stays pending with every slot taken
    send_arrivals(1);
    repeat (20) next_cycle();
    @(negedge logic_clk);
    assert (!rx_desc_valid && m_pending == 1)
      else fail_now("allocation_order: a descriptor appeared with every slot busy");

    test_name = "backpressure";
    apply_reset();
    stall_en = 1'b1;
    for (int r = 0; r < 16; r++) begin
      send_arrivals(8);
      wait_idle();
    end
    stall_en = 1'b0;

    test_name = "slot_release";
    send_msg(5, slot_free_word(3'd3));
    send_msg(9, slot_free_word(3'd0));
    send_arrivals(1);
    wait_idle();
    send_arrivals(1);
    wait_idle();

    test_name = "core_disable";
    send_msg(2, core_status_word(1'b0));
    send_msg(1, slot_free_word(3'd4));
    send_msg(2, slot_free_word(3'd4));
    send_msg(3, slot_free_word(3'd4));
    // reserved codes 0 and 3 must be ignored
    send_msg(2, {2'd0, 59'd0, 3'b101});
    send_msg(5, {2'd3, 59'd0, 3'd2});
    send_arrivals(2);
    wait_idle();
    send_msg(2, core_status_word(1'b1));
    send_arrivals(1);
    wait_idle();
    // all slots busy again, a stray free of core 2 slot 5 would show up here
    send_arrivals(1);
    repeat (20) next_cycle();
    @(negedge logic_clk);
    assert (!rx_desc_valid && m_pending == 1)
      else fail_now("core_disable: a descriptor appeared with every slot busy");

    test_name = "overflow";
    core = $random(seed) & 15;
    for (int i = 0; i < 8; i++) begin
      next_cycle();
      core_msg_valid[core] <= 1'b1;
      core_msg_data[core]  <= msg_pkg::core_msg_u'({2'd0, 30'd0, 32'($random(seed))});
    end
    next_cycle();
    core_msg_valid <= '0;
    wait_drained();
    ovf_allowed = '1;
    for (int i = 0; i < 32; i++) begin
      next_cycle();
      core_msg_valid <= '1;
      for (int c = 0; c < msg_pkg::CORE_COUNT; c++) begin
        core_msg_data[c] <= msg_pkg::core_msg_u'({2'd3, 30'd0, 32'($random(seed))});
      end
    end
    next_cycle();
    core_msg_valid <= '0;
    @(negedge logic_clk);
    assert (msg_overflow == '1)
      else fail_now($sformatf("[ERROR] overflow: expected msg_overflow %h, actual %h",
        16'hffff, msg_overflow));
    wait_drained();
    assert (msg_overflow == '1)
      else fail_now($sformatf("[ERROR] overflow: expected msg_overflow %h, actual %h",
        16'hffff, msg_overflow));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- hw/riscv_msg_ctrl.sv
`timescale 1ns/100ps

module riscv_msg_ctrl (
  input  logic                                         logic_clk,
  input  logic                                         rst_n,
  input  logic [msg_pkg::CORE_COUNT-1:0]               core_msg_valid,
  input  msg_pkg::core_msg_u [msg_pkg::CORE_COUNT-1:0] core_msg_data,
  input  logic                                         pkt_arrival,
  input  logic                                         rx_desc_ready,
  output msg_pkg::rx_desc_t                            rx_desc,
  output logic                                         rx_desc_valid,
  output logic [msg_pkg::CORE_COUNT-1:0]               msg_overflow
);

  // merged message stream toward the tracker
  msg_pkg::arb_msg_t arb_msg;
  logic              msg_valid;
  logic              msg_ready;

  core_msg_arbiter u_core_msg_arbiter (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .core_msg_valid (core_msg_valid),
    .core_msg_data  (core_msg_data),
    .msg_ready      (msg_ready),
    .arb_msg        (arb_msg),
    .msg_valid      (msg_valid),
    .msg_overflow   (msg_overflow)
  );

  slot_tracker u_slot_tracker (
    .logic_clk     (logic_clk),
    .rst_n         (rst_n),
    .arb_msg       (arb_msg),
    .msg_valid     (msg_valid),
    .pkt_arrival   (pkt_arrival),
    .rx_desc_ready (rx_desc_ready),
    .msg_ready     (msg_ready),
    .rx_desc       (rx_desc),
    .rx_desc_valid (rx_desc_valid)
  );

endmodule

//--- hw/slot_tracker.sv
`timescale 1ns/100ps

module slot_tracker (
  input  logic              logic_clk,
  input  logic              rst_n,
  input  msg_pkg::arb_msg_t arb_msg,
  input  logic              msg_valid,
  input  logic              pkt_arrival,
  input  logic              rx_desc_ready,
  output logic              msg_ready,
  output msg_pkg::rx_desc_t rx_desc,
  output logic              rx_desc_valid
);

  logic [msg_pkg::CORE_COUNT-1:0][msg_pkg::SLOT_COUNT-1:0] busy;
  logic [msg_pkg::CORE_COUNT-1:0]                          core_en;
  logic [msg_pkg::CORE_COUNT-1:0]                          core_avail;
  logic [$clog2(msg_pkg::PENDING_MAX+1)-1:0]               pending;
  logic [msg_pkg::CORE_NO_WIDTH-1:0]                       last_issue;
  logic [msg_pkg::SLOT_NO_WIDTH-1:0]                       free_slot;
  msg_pkg::rr_pick_t                                       pick;
  logic                                                    msg_accept;
  logic                                                    is_slot_free;
  logic                                                    is_core_status;
  logic                                                    desc_free;
  logic                                                    have_pkt;
  logic                                                    issue;

  assign msg_accept     = msg_valid && msg_ready;
  assign is_slot_free   = (arb_msg.msg.slot_free.msg_type == msg_pkg::MSG_SLOT_FREE);
  assign is_core_status = (arb_msg.msg.core_status.msg_type == msg_pkg::MSG_CORE_STATUS);

  // a core qualifies when enabled and at least one slot is free
  always_comb begin
    for (int c = 0; c < msg_pkg::CORE_COUNT; c++) begin
      core_avail[c] = core_en[c] && (busy[c] != '1);
    end
  end

  assign pick = msg_pkg::rr_pick(core_avail, last_issue);

  // lowest free slot of the picked core
  always_comb begin
    free_slot = '0;
    for (int s = msg_pkg::SLOT_COUNT - 1; s >= 0; s--) begin
      if (!busy[pick.core_no][s]) begin
        free_slot = s[msg_pkg::SLOT_NO_WIDTH-1:0];
      end
    end
  end

  // an arrival strobe counts in its own cycle, giving one cycle to valid
  assign have_pkt  = (pending != '0) || pkt_arrival;
  assign desc_free = !rx_desc_valid || rx_desc_ready;
  assign issue     = desc_free && have_pkt && pick.found;

  always_ff @(posedge logic_clk) begin
    if (issue) begin
      rx_desc.core_no <= pick.core_no;
      rx_desc.slot_no <= free_slot;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      msg_ready     <= 1'b0;
      rx_desc_valid <= 1'b0;
      busy          <= '0;
      core_en       <= '1;
      pending       <= '0;
      last_issue    <= '1;
    end else begin
      msg_ready <= 1'b1;

      if (issue) begin
        rx_desc_valid <= 1'b1;
      end else if (rx_desc_ready) begin
        rx_desc_valid <= 1'b0;
      end

      // issue only touches a free bit, a slot free only a busy one
      if (issue) begin
        busy[pick.core_no][free_slot] <= 1'b1;
        last_issue                    <= pick.core_no;
      end
      if (msg_accept && is_slot_free) begin
        busy[arb_msg.core_no][arb_msg.msg.slot_free.slot_no] <= 1'b0;
      end
      if (msg_accept && is_core_status) begin
        core_en[arb_msg.core_no] <= arb_msg.msg.core_status.accept;
      end

      // saturating count, an arrival at the limit is lost
      if (pkt_arrival && !issue && (pending != msg_pkg::PENDING_MAX)) begin
        pending <= pending + 1'b1;
      end else if (issue && !pkt_arrival) begin
        pending <= pending - 1'b1;
      end
    end
  end

  a_slot_free_was_busy: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (msg_accept && is_slot_free)
      |-> busy[arb_msg.core_no][arb_msg.msg.slot_free.slot_no]
  ) else $error("slot free message for a slot that is already free");

  a_desc_stable: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (rx_desc_valid && !rx_desc_ready) |=> (rx_desc_valid && $stable(rx_desc))
  ) else $error("rx_desc changed while stalled");

endmodule

//--- hw/core_msg_arbiter.sv
`timescale 1ns/100ps

module core_msg_arbiter (
  input  logic                                          logic_clk,
  input  logic                                          rst_n,
  input  logic [msg_pkg::CORE_COUNT-1:0]                core_msg_valid,
  input  msg_pkg::core_msg_u [msg_pkg::CORE_COUNT-1:0]  core_msg_data,
  input  logic                                          msg_ready,
  output msg_pkg::arb_msg_t                             arb_msg,
  output logic                                          msg_valid,
  output logic [msg_pkg::CORE_COUNT-1:0]                msg_overflow
);

  msg_pkg::core_msg_u                  fifo_head [msg_pkg::CORE_COUNT];
  logic [msg_pkg::CORE_COUNT-1:0]      fifo_empty;
  logic [msg_pkg::CORE_COUNT-1:0]      fifo_pop;
  logic [msg_pkg::CORE_NO_WIDTH-1:0]   last_grant;
  msg_pkg::rr_pick_t                   grant;
  logic                                load;

  genvar g;
  generate
    for (g = 0; g < msg_pkg::CORE_COUNT; g++) begin : g_core_fifo
      core_msg_fifo u_core_msg_fifo (
        .logic_clk (logic_clk),
        .rst_n     (rst_n),
        .push      (core_msg_valid[g]),
        .push_msg  (core_msg_data[g]),
        .pop       (fifo_pop[g]),
        .head_msg  (fifo_head[g]),
        .empty     (fifo_empty[g]),
        .overflow  (msg_overflow[g])
      );
    end
  endgenerate

  // output stage can take a new message when empty or being drained
  assign load  = !msg_valid || msg_ready;
  assign grant = msg_pkg::rr_pick(~fifo_empty, last_grant);

  always_comb begin
    fifo_pop = '0;
    if (load && grant.found) begin
      fifo_pop[grant.core_no] = 1'b1;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (load && grant.found) begin
      arb_msg.msg     <= fifo_head[grant.core_no];
      arb_msg.core_no <= grant.core_no;
    end
  end

  // last_grant starts at the top core so core 0 wins first
  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      msg_valid  <= 1'b0;
      last_grant <= '1;
    end else if (load) begin
      msg_valid <= grant.found;
      if (grant.found) begin
        last_grant <= grant.core_no;
      end
    end
  end

  a_hold_under_backpressure: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    (msg_valid && !msg_ready) |=> (msg_valid && $stable(arb_msg))
  ) else $error("arb_msg changed while stalled");

endmodule

//--- hw/core_msg_fifo.sv
`timescale 1ns/100ps

module core_msg_fifo (
  input  logic               logic_clk,
  input  logic               rst_n,
  input  logic               push,
  input  msg_pkg::core_msg_u push_msg,
  input  logic               pop,
  output msg_pkg::core_msg_u head_msg,
  output logic               empty,
  output logic               overflow
);

  // pointers carry one extra wrap bit to tell full from empty
  logic [msg_pkg::CORE_FIFO_ADDR_SIZE:0]   wr_ptr;
  logic [msg_pkg::CORE_FIFO_ADDR_SIZE:0]   rd_ptr;
  logic [msg_pkg::CORE_FIFO_ADDR_SIZE-1:0] wr_addr;
  logic [msg_pkg::CORE_FIFO_ADDR_SIZE-1:0] rd_addr;
  msg_pkg::core_msg_u                      mem [2**msg_pkg::CORE_FIFO_ADDR_SIZE];
  logic                                    full;
  logic                                    push_ok;

  assign wr_addr = wr_ptr[msg_pkg::CORE_FIFO_ADDR_SIZE-1:0];
  assign rd_addr = rd_ptr[msg_pkg::CORE_FIFO_ADDR_SIZE-1:0];

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[msg_pkg::CORE_FIFO_ADDR_SIZE] != rd_ptr[msg_pkg::CORE_FIFO_ADDR_SIZE])
              && (wr_addr == rd_addr);

  // a push into a full queue is lost, even with a pop in the same cycle
  assign push_ok  = push && !full;
  assign head_msg = mem[rd_addr];

  always_ff @(posedge logic_clk) begin
    if (push_ok) begin
      mem[wr_addr] <= push_msg;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  a_no_pop_when_empty: assert property (
    @(posedge logic_clk) disable iff (!rst_n)
    pop |-> !empty
  ) else $error("core_msg_fifo popped while empty");

endmodule

//--- hw/msg_pkg.sv
package msg_pkg;

  localparam int CORE_COUNT          = 16;
  localparam int CORE_NO_WIDTH       = 4;
  localparam int SLOT_COUNT          = 8;
  localparam int SLOT_NO_WIDTH       = 3;
  localparam int MSG_WIDTH           = 64;
  localparam int CORE_FIFO_ADDR_SIZE = 3;
  localparam int PENDING_MAX         = 15;

  // codes 0 and 3 are reserved, such messages are dropped by the tracker
  typedef enum logic [1:0] {
    MSG_SLOT_FREE   = 2'd1,
    MSG_CORE_STATUS = 2'd2
  } msg_type_e;

  typedef struct packed {
    msg_type_e                  msg_type;
    logic [MSG_WIDTH-3-SLOT_NO_WIDTH:0] pad;
    logic [SLOT_NO_WIDTH-1:0]   slot_no;
  } slot_free_msg_t;

  typedef struct packed {
    msg_type_e                  msg_type;
    logic [MSG_WIDTH-4:0]       pad;
    logic                       accept;
  } core_status_msg_t;

  // one 64-bit core message, type always in bits 63:62
  typedef union packed {
    slot_free_msg_t   slot_free;
    core_status_msg_t core_status;
  } core_msg_u;

  typedef struct packed {
    core_msg_u                msg;
    logic [CORE_NO_WIDTH-1:0] core_no;
  } arb_msg_t;

  typedef struct packed {
    logic [CORE_NO_WIDTH-1:0] core_no;
    logic [SLOT_NO_WIDTH-1:0] slot_no;
  } rx_desc_t;

  typedef struct packed {
    logic                     found;
    logic [CORE_NO_WIDTH-1:0] core_no;
  } rr_pick_t;

  // first requesting core after last, last itself is checked at the end
  function automatic rr_pick_t rr_pick(input logic [CORE_COUNT-1:0]    req,
                                       input logic [CORE_NO_WIDTH-1:0] last);
    rr_pick_t                 pick;
    logic [CORE_NO_WIDTH-1:0] idx;
    pick.found   = 1'b0;
    pick.core_no = last;
    for (int i = 1; i <= CORE_COUNT; i++) begin
      idx = last + i[CORE_NO_WIDTH-1:0];
      if (!pick.found && req[idx]) begin
        pick.found   = 1'b1;
        pick.core_no = idx;
      end
    end
    return pick;
  endfunction

endpackage
